//--- Makefile
# Verilator build and run for the AXI4-Lite downsizer testbench.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_axil_dw_downsizer
RTL_TOP   ?= axil_dw_downsizer
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
SEED      ?= 55
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)."; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation ended early, see $(LOG)."; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_axil_dw_downsizer.sv
// Testbench for the AXI4-Lite data width downsizer.
// Wide requests go in on the slave port, a narrow memory answers on the master
// port, and a wide reference memory predicts every B and R response.
`timescale 1ns/10ps
`default_nettype none

module tb_axil_dw_downsizer;

  import axil_dw_pkg::*;

  // The directed tests issue 11 wide transactions, the random test 2 per draw at most.
  localparam int N_RAND         = 100;
  localparam int TOTAL_TXN      = 11 + 2 * N_RAND;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_TXN;

  logic           clk_i;
  logic           rst_i;
  logic           slv_aw_valid_i, slv_aw_ready_o;
  axil_ax_t       slv_aw_i;
  logic           slv_w_valid_i, slv_w_ready_o;
  axil_w_wide_t   slv_w_i;
  logic           slv_b_valid_o, slv_b_ready_i;
  axil_resp_e     slv_b_resp_o;
  logic           slv_ar_valid_i, slv_ar_ready_o;
  axil_ax_t       slv_ar_i;
  logic           slv_r_valid_o, slv_r_ready_i;
  axil_r_wide_t   slv_r_o;
  logic           mst_aw_valid_o, mst_aw_ready_i;
  axil_ax_t       mst_aw_o;
  logic           mst_w_valid_o, mst_w_ready_i;
  axil_w_narrow_t mst_w_o;
  logic           mst_b_valid_i, mst_b_ready_o;
  axil_resp_e     mst_b_resp_i;
  logic           mst_ar_valid_o, mst_ar_ready_i;
  axil_ax_t       mst_ar_o;
  logic           mst_r_valid_i, mst_r_ready_o;
  axil_r_narrow_t mst_r_i;

  // Wide requests waiting for the slave driver, and the responses they should get.
  axil_ax_t       aw_q[$];
  axil_w_wide_t   w_q[$];
  axil_ax_t       ar_q[$];
  axil_resp_e     exp_b_q[$];
  axil_r_wide_t   exp_r_q[$];
  // Narrow addresses expected on the master port, in beat order.
  axil_ax_t       exp_maw_q[$];
  axil_ax_t       exp_mar_q[$];
  // State of the narrow memory behind the master port.
  logic [15:0]    maw_q[$];
  axil_w_narrow_t mw_q[$];
  axil_resp_e     mb_q[$];
  axil_r_narrow_t mr_q[$];
  logic [7:0]     mem [0:65535];
  logic [7:0]     ref_mem [0:65535];

  string test_name    = "none";
  int    test_checks  = 0;
  int    test_errs    = 0;
  int    total_checks = 0;
  int    total_errs   = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;
  int    b_seen       = 0;
  int    r_seen       = 0;
  int    cycles       = 0;

  tb_clk_gen clk_gen_i (
    .clk_o (clk_i)
  );

  axil_dw_downsizer axil_dw_downsizer_i (.*);

  // Initial memory contents in which every address bit takes part.
  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3C;
  endfunction

  // A narrow beat keeps the wide request but carries its beat index in address bit 2.
  function automatic axil_ax_t beat_ax(input axil_ax_t ax, input logic beat);
    axil_ax_t nax;
    nax         = ax;
    nax.addr[2] = beat;
    return nax;
  endfunction

  // Beat b carries strobe bits 4b+3 down to 4b into the narrow word whose bit 2 is b.
  // Writes into the error region are dropped, as the narrow memory does.
  function automatic axil_resp_e ref_write(input axil_ax_t ax, input axil_w_wide_t w);
    logic [15:0] base;
    if (ax.addr[12]) begin
      return RESP_SLVERR;
    end
    for (int b = 0; b < 2; b++) begin
      base = {ax.addr[15:3], b[0], 2'b00};
      for (int j = 0; j < 4; j++) begin
        if (w.strb[4*b+j]) begin
          ref_mem[base + 16'(j)] = w.data[32*b + 8*j +: 8];
        end
      end
    end
    return RESP_OKAY;
  endfunction

  // The wide read is beat 1 over beat 0, its code the OR of both beat codes.
  function automatic axil_r_wide_t ref_read(input axil_ax_t ax);
    axil_r_wide_t r;
    logic [15:0]  base;
    r.resp = RESP_OKAY;
    for (int b = 0; b < 2; b++) begin
      base = {ax.addr[15:3], b[0], 2'b00};
      for (int j = 0; j < 4; j++) begin
        r.data[32*b + 8*j +: 8] = ref_mem[base + 16'(j)];
      end
      r.resp = axil_resp_e'(r.resp | (base[12] ? RESP_SLVERR : RESP_OKAY));
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [71:0] exp, input logic [71:0] act);
    test_checks++;
    total_checks++;
    if (act !== exp) begin
      test_errs++;
      total_errs++;
      $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    test_errs++;
    total_errs++;
    $display("Error in %s: %s.", test_name, msg);
  endtask

  task automatic issue_write(input logic [15:0] addr, input logic [63:0] data,
                             input logic [7:0] strb);
    axil_ax_t     ax;
    axil_w_wide_t w;
    ax.addr = addr;
    ax.prot = 3'($urandom);
    w.data  = data;
    w.strb  = strb;
    aw_q.push_back(ax);
    w_q.push_back(w);
    exp_maw_q.push_back(beat_ax(ax, 1'b0));
    exp_maw_q.push_back(beat_ax(ax, 1'b1));
    exp_b_q.push_back(ref_write(ax, w));
  endtask

  task automatic issue_read(input logic [15:0] addr);
    axil_ax_t ax;
    ax.addr = addr;
    ax.prot = 3'($urandom);
    ar_q.push_back(ax);
    exp_mar_q.push_back(beat_ax(ax, 1'b0));
    exp_mar_q.push_back(beat_ax(ax, 1'b1));
    exp_r_q.push_back(ref_read(ax));
  endtask

  // Returns once every issued request has been sent and answered.
  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (aw_q.size() + w_q.size() + ar_q.size() + exp_b_q.size() + exp_r_q.size() != 0);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("Test %s finished: %0d checks, %0d errors", test_name, test_checks, test_errs);
  endtask

  // Slave side. Each request is held until taken, and B and R are checked as they arrive.
  // Inputs change on the falling edge and handshakes are judged 1 ns later.
  initial begin : slave_side
    logic aw_taken;
    logic w_taken;
    logic ar_taken;
    slv_aw_valid_i = 1'b0;
    slv_aw_i       = '0;
    slv_w_valid_i  = 1'b0;
    slv_w_i        = '0;
    slv_b_ready_i  = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_i       = '0;
    slv_r_ready_i  = 1'b0;
    aw_taken       = 1'b0;
    w_taken        = 1'b0;
    ar_taken       = 1'b0;
    forever begin
      @(negedge clk_i);
      if (aw_taken) slv_aw_valid_i = 1'b0;
      if (!slv_aw_valid_i && aw_q.size() != 0 && $urandom_range(0, 3) != 0) begin
        slv_aw_i       = aw_q.pop_front();
        slv_aw_valid_i = 1'b1;
      end
      if (w_taken) slv_w_valid_i = 1'b0;
      if (!slv_w_valid_i && w_q.size() != 0 && $urandom_range(0, 3) != 0) begin
        slv_w_i       = w_q.pop_front();
        slv_w_valid_i = 1'b1;
      end
      if (ar_taken) slv_ar_valid_i = 1'b0;
      if (!slv_ar_valid_i && ar_q.size() != 0 && $urandom_range(0, 3) != 0) begin
        slv_ar_i       = ar_q.pop_front();
        slv_ar_valid_i = 1'b1;
      end
      slv_b_ready_i = ($urandom_range(0, 3) != 0);
      slv_r_ready_i = ($urandom_range(0, 3) != 0);
      #1;
      aw_taken = slv_aw_valid_i && slv_aw_ready_o;
      w_taken  = slv_w_valid_i && slv_w_ready_o;
      ar_taken = slv_ar_valid_i && slv_ar_ready_o;
      if (slv_b_valid_o && slv_b_ready_i) begin
        b_seen++;
        if (exp_b_q.size() == 0) report_error("B response with no write outstanding");
        else check_value("B resp", 72'(exp_b_q.pop_front()), 72'(slv_b_resp_o));
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        r_seen++;
        if (exp_r_q.size() == 0) report_error("R response with no read outstanding");
        else check_value("R data and resp", 72'(exp_r_q.pop_front()), 72'(slv_r_o));
      end
    end
  end

  // Narrow memory on the master port with random ready and random response delay.
  // Any narrow address with bit 12 set answers SLVERR and is never written.
  initial begin : master_side
    logic           b_taken;
    logic           r_taken;
    logic [15:0]    waddr;
    logic [15:0]    base;
    axil_w_narrow_t wbeat;
    axil_r_narrow_t rbeat;
    axil_resp_e     wresp;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_resp_i   = RESP_OKAY;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_i        = '0;
    b_taken        = 1'b0;
    r_taken        = 1'b0;
    forever begin
      @(negedge clk_i);
      mst_aw_ready_i = ($urandom_range(0, 3) != 0);
      mst_w_ready_i  = ($urandom_range(0, 3) != 0);
      mst_ar_ready_i = ($urandom_range(0, 3) != 0);
      if (b_taken) mst_b_valid_i = 1'b0;
      if (!mst_b_valid_i && mb_q.size() != 0 && $urandom_range(0, 2) != 0) begin
        mst_b_resp_i  = mb_q.pop_front();
        mst_b_valid_i = 1'b1;
      end
      if (r_taken) mst_r_valid_i = 1'b0;
      if (!mst_r_valid_i && mr_q.size() != 0 && $urandom_range(0, 2) != 0) begin
        mst_r_i       = mr_q.pop_front();
        mst_r_valid_i = 1'b1;
      end
      #1;
      b_taken = mst_b_valid_i && mst_b_ready_o;
      r_taken = mst_r_valid_i && mst_r_ready_o;
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        if (exp_maw_q.size() == 0) report_error("narrow AW with no wide write outstanding");
        else check_value("narrow AW", 72'(exp_maw_q.pop_front()), 72'(mst_aw_o));
        maw_q.push_back(mst_aw_o.addr);
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        mw_q.push_back(mst_w_o);
      end
      // A narrow write lands once both its address and its data are in.
      if (maw_q.size() != 0 && mw_q.size() != 0) begin
        waddr = maw_q.pop_front();
        wbeat = mw_q.pop_front();
        base  = {waddr[15:2], 2'b00};
        wresp = RESP_OKAY;
        if (waddr[12]) wresp = RESP_SLVERR;
        for (int j = 0; j < 4; j++) begin
          if (wbeat.strb[j] && !waddr[12]) mem[base + 16'(j)] = wbeat.data[8*j +: 8];
        end
        mb_q.push_back(wresp);
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        if (exp_mar_q.size() == 0) report_error("narrow AR with no wide read outstanding");
        else check_value("narrow AR", 72'(exp_mar_q.pop_front()), 72'(mst_ar_o));
        base       = {mst_ar_o.addr[15:2], 2'b00};
        rbeat.resp = RESP_OKAY;
        if (mst_ar_o.addr[12]) rbeat.resp = RESP_SLVERR;
        for (int j = 0; j < 4; j++) begin
          rbeat.data[8*j +: 8] = mem[base + 16'(j)];
        end
        mr_q.push_back(rbeat);
      end
    end
  end

  // The whole run is bounded by the number of transactions it issues.
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in %s, transactions still pending.", cycles, test_name);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin : main
    logic [15:0] addr;
    logic [15:0] wr_addrs[$];
    int          b_start;
    int          r_start;
    void'($urandom(55));
    rst_i = 1'b1;
    for (int i = 0; i < 65536; i++) begin
      mem[i]     = fill_byte(16'(i));
      ref_mem[i] = fill_byte(16'(i));
    end
    // Reset covers four rising edges and is released on the following falling edge.
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Valids low, slave request readies high.
    start_test("reset_state");
    #1;
    check_value("valids and readies", 72'(8'b0000_0111),
                72'({slv_b_valid_o, slv_r_valid_o, mst_aw_valid_o, mst_w_valid_o,
                     mst_ar_valid_o, slv_aw_ready_o, slv_w_ready_o, slv_ar_ready_o}));
    end_test();

    start_test("full_write_read");
    issue_write(16'h0108, {$urandom, $urandom}, 8'hFF);
    wait_idle();
    issue_read(16'h0108);
    wait_idle();
    end_test();

    // The second write touches bytes in both beats.
    start_test("partial_strobe");
    issue_write(16'h0230, 64'h0123_4567_89AB_CDEF, 8'hFF);
    issue_write(16'h0230, {$urandom, $urandom}, 8'b1001_0110);
    wait_idle();
    issue_read(16'h0230);
    wait_idle();
    end_test();

    // Bit 2 set in the wide address must still give beat 0 first.
    start_test("narrow_addr");
    issue_write(16'h0A38, {$urandom, $urandom}, 8'hFF);
    issue_write(16'h0A3C, {$urandom, $urandom}, 8'hF0);
    issue_read(16'h0C44);
    issue_read(16'h0C48);
    wait_idle();
    end_test();

    start_test("slverr");
    issue_write(16'h1010, {$urandom, $urandom}, 8'hFF);
    wait_idle();
    issue_read(16'h1010);
    wait_idle();
    end_test();

    // Writes stay below bit 11 and reads above it, so no read races a write.
    start_test("random_traffic");
    b_start = b_seen;
    r_start = r_seen;
    for (int i = 0; i < N_RAND; i++) begin
      if ($urandom_range(0, 1) == 1) begin
        addr = {5'b00000, 8'($urandom), 3'($urandom)};
        issue_write(addr, {$urandom, $urandom}, 8'($urandom));
        wr_addrs.push_back(addr);
      end else begin
        addr = {5'b00001, 8'($urandom), 3'($urandom)};
        issue_read(addr);
      end
    end
    wait_idle();
    foreach (wr_addrs[k]) begin
      issue_read(wr_addrs[k]);
    end
    wait_idle();
    check_value("B count", 72'(wr_addrs.size()), 72'(b_seen - b_start));
    check_value("R count", 72'(N_RAND), 72'(r_seen - r_start));
    end_test();

    // A few idle cycles expose any late or duplicated response.
    repeat (20) @(negedge clk_i);
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, total_checks, total_errs);
    if (total_errs == 0 && tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
// Testbench clock generator.
// Free running clock that starts low, 10 ns period by default.
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/axil_dw_pkg.sv
verilog/axil_spill_reg.sv
verilog/axil_addr_splitter.sv
verilog/axil_w_splitter.sv
verilog/axil_b_merge.sv
verilog/axil_r_merge.sv
verilog/axil_dw_downsizer.sv
test/tb_clk_gen.sv
test/tb_axil_dw_downsizer.sv

//--- verilog/axil_addr_splitter.sv
// Address splitter for the AW or AR channel.
// One wide request becomes DOWNSIZE_FACTOR narrow requests, one per beat,
// with the lane select field of the address replaced by the beat index.
`timescale 1ns/10ps
`default_nettype none

`include "axil_dw_consts.svh"

module axil_addr_splitter (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   slv_valid_i,
  output logic                  slv_ready_o,
  input  axil_dw_pkg::axil_ax_t slv_ax_i,
  output logic                  mst_valid_o,
  input  wire                   mst_ready_i,
  output axil_dw_pkg::axil_ax_t mst_ax_o
);

  import axil_dw_pkg::*;

  axil_ax_t  spill_ax;
  logic      spill_valid;
  logic      spill_ready;
  axil_sel_t sel_q;
  logic      last_beat;
  logic      beat_done;

  // The wide request waits here until its last narrow beat has gone out.
  axil_spill_reg #(
    .T (axil_ax_t)
  ) i_spill (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (slv_valid_i),
    .ready_o (slv_ready_o),
    .data_i  (slv_ax_i),
    .valid_o (spill_valid),
    .ready_i (spill_ready),
    .data_o  (spill_ax)
  );

  assign last_beat   = &sel_q;
  assign beat_done   = mst_valid_o & mst_ready_i;
  assign mst_valid_o = spill_valid;
  // Pop the wide entry together with the last narrow beat.
  assign spill_ready = mst_ready_i & last_beat;

  // Only the lane select bits change; prot and the other address bits pass as they are.
  always_comb begin
    mst_ax_o = spill_ax;
    mst_ax_o.addr[`SEL_OFFSET +: `SEL_W] = sel_q;
  end

  // The beat counter wraps to zero after the last beat.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q <= '0;
    end else if (beat_done) begin
      sel_q <= sel_q + axil_sel_t'(1);
    end
  end

  a_stable_ax : assert property (@(posedge clk_i) disable iff (rst_i)
      (mst_valid_o && !mst_ready_i) |=> $stable(mst_ax_o))
    else $error("Address channel changed before its handshake.");

endmodule

`default_nettype wire

//--- verilog/axil_b_merge.sv
// Write response merger.
// Folds the DOWNSIZE_FACTOR narrow B responses into one slave B response
// whose code is the OR of all beat codes.
`timescale 1ns/10ps
`default_nettype none

`include "axil_dw_consts.svh"

module axil_b_merge (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     mst_valid_i,
  output logic                    mst_ready_o,
  input  axil_dw_pkg::axil_resp_e mst_resp_i,
  output logic                    slv_valid_o,
  input  wire                     slv_ready_i,
  output axil_dw_pkg::axil_resp_e slv_resp_o
);

  import axil_dw_pkg::*;

  axil_sel_t  sel_q;
  axil_resp_e resp_q;
  logic       last_beat;
  logic       beat_done;

  assign last_beat = &sel_q;
  assign beat_done = mst_valid_i & mst_ready_o;

  // Earlier beats are absorbed at once; the last one waits for the slave.
  assign mst_ready_o = last_beat ? slv_ready_i : 1'b1;
  assign slv_valid_o = last_beat & mst_valid_i;
  assign slv_resp_o  = axil_resp_e'(resp_q | mst_resp_i);

  // The accumulator starts each transaction at OKAY.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q  <= '0;
      resp_q <= RESP_OKAY;
    end else if (beat_done) begin
      sel_q  <= sel_q + axil_sel_t'(1);
      resp_q <= last_beat ? RESP_OKAY : slv_resp_o;
    end
  end

  a_stable_b : assert property (@(posedge clk_i) disable iff (rst_i)
      (slv_valid_o && !slv_ready_i) |=> $stable(slv_resp_o))
    else $error("B channel changed before its handshake.");

endmodule

`default_nettype wire

//--- verilog/axil_dw_consts.svh
// AXI4-Lite downsizer constants.
// Bus widths and the beat select geometry shared by the whole design.
`ifndef AXIL_DW_CONSTS_SVH
`define AXIL_DW_CONSTS_SVH

// Address width of both ports.
`define AXIL_ADDR_W 16

// Data widths of the wide slave port and the narrow master port.
`define AXIL_SLV_DATA_W 64
`define AXIL_MST_DATA_W 32

// One strobe bit per data byte.
`define AXIL_SLV_STRB_W (`AXIL_SLV_DATA_W / 8)
`define AXIL_MST_STRB_W (`AXIL_MST_DATA_W / 8)

// Narrow beats per wide transaction, the beat index width and its address position.
`define DOWNSIZE_FACTOR (`AXIL_SLV_DATA_W / `AXIL_MST_DATA_W)
`define SEL_W           ($clog2(`DOWNSIZE_FACTOR))
`define SEL_OFFSET      ($clog2(`AXIL_MST_STRB_W))

`endif

//--- verilog/axil_dw_downsizer.sv
// AXI4-Lite data width downsizer.
// A wide slave port is served by a narrow master port; every wide transfer
// becomes DOWNSIZE_FACTOR narrow transfers and their responses are merged.
`timescale 1ns/10ps
`default_nettype none

module axil_dw_downsizer (
  input  wire                         clk_i,
  input  wire                         rst_i,
  // Slave port, wide data.
  input  wire                         slv_aw_valid_i,
  output logic                        slv_aw_ready_o,
  input  axil_dw_pkg::axil_ax_t       slv_aw_i,
  input  wire                         slv_w_valid_i,
  output logic                        slv_w_ready_o,
  input  axil_dw_pkg::axil_w_wide_t   slv_w_i,
  output logic                        slv_b_valid_o,
  input  wire                         slv_b_ready_i,
  output axil_dw_pkg::axil_resp_e     slv_b_resp_o,
  input  wire                         slv_ar_valid_i,
  output logic                        slv_ar_ready_o,
  input  axil_dw_pkg::axil_ax_t       slv_ar_i,
  output logic                        slv_r_valid_o,
  input  wire                         slv_r_ready_i,
  output axil_dw_pkg::axil_r_wide_t   slv_r_o,
  // Master port, narrow data.
  output logic                        mst_aw_valid_o,
  input  wire                         mst_aw_ready_i,
  output axil_dw_pkg::axil_ax_t       mst_aw_o,
  output logic                        mst_w_valid_o,
  input  wire                         mst_w_ready_i,
  output axil_dw_pkg::axil_w_narrow_t mst_w_o,
  input  wire                         mst_b_valid_i,
  output logic                        mst_b_ready_o,
  input  axil_dw_pkg::axil_resp_e     mst_b_resp_i,
  output logic                        mst_ar_valid_o,
  input  wire                         mst_ar_ready_i,
  output axil_dw_pkg::axil_ax_t       mst_ar_o,
  input  wire                         mst_r_valid_i,
  output logic                        mst_r_ready_o,
  input  axil_dw_pkg::axil_r_narrow_t mst_r_i
);

  // Write address, one narrow request per beat.
  axil_addr_splitter i_aw_splitter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .slv_valid_i (slv_aw_valid_i),
    .slv_ready_o (slv_aw_ready_o),
    .slv_ax_i    (slv_aw_i),
    .mst_valid_o (mst_aw_valid_o),
    .mst_ready_i (mst_aw_ready_i),
    .mst_ax_o    (mst_aw_o)
  );

  // Write data runs independently of the address path.
  axil_w_splitter i_w_splitter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .slv_valid_i (slv_w_valid_i),
    .slv_ready_o (slv_w_ready_o),
    .slv_w_i     (slv_w_i),
    .mst_valid_o (mst_w_valid_o),
    .mst_ready_i (mst_w_ready_i),
    .mst_w_o     (mst_w_o)
  );

  axil_b_merge i_b_merge (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mst_valid_i (mst_b_valid_i),
    .mst_ready_o (mst_b_ready_o),
    .mst_resp_i  (mst_b_resp_i),
    .slv_valid_o (slv_b_valid_o),
    .slv_ready_i (slv_b_ready_i),
    .slv_resp_o  (slv_b_resp_o)
  );

  // Read address uses the same splitter as the write address.
  axil_addr_splitter i_ar_splitter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .slv_valid_i (slv_ar_valid_i),
    .slv_ready_o (slv_ar_ready_o),
    .slv_ax_i    (slv_ar_i),
    .mst_valid_o (mst_ar_valid_o),
    .mst_ready_i (mst_ar_ready_i),
    .mst_ax_o    (mst_ar_o)
  );

  axil_r_merge i_r_merge (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mst_valid_i (mst_r_valid_i),
    .mst_ready_o (mst_r_ready_o),
    .mst_r_i     (mst_r_i),
    .slv_valid_o (slv_r_valid_o),
    .slv_ready_i (slv_r_ready_i),
    .slv_r_o     (slv_r_o)
  );

endmodule

`default_nettype wire

//--- verilog/axil_dw_pkg.sv
// AXI4-Lite downsizer types.
// Channel payload structs for both ports, the response codes and the beat index.
`default_nettype none

`include "axil_dw_consts.svh"

package axil_dw_pkg;

  // Response codes; merging two responses is the bitwise OR of the codes.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_e;

  // Address request, shared by AW and AR on both ports.
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [2:0]              prot;
  } axil_ax_t;

  // Write data on the wide slave port.
  typedef struct packed {
    logic [`AXIL_SLV_DATA_W-1:0] data;
    logic [`AXIL_SLV_STRB_W-1:0] strb;
  } axil_w_wide_t;

  // Write data on the narrow master port.
  typedef struct packed {
    logic [`AXIL_MST_DATA_W-1:0] data;
    logic [`AXIL_MST_STRB_W-1:0] strb;
  } axil_w_narrow_t;

  // Read response on the wide slave port.
  typedef struct packed {
    logic [`AXIL_SLV_DATA_W-1:0] data;
    axil_resp_e                  resp;
  } axil_r_wide_t;

  // Read response on the narrow master port.
  typedef struct packed {
    logic [`AXIL_MST_DATA_W-1:0] data;
    axil_resp_e                  resp;
  } axil_r_narrow_t;

  // Index of the narrow beat within one wide transaction.
  typedef logic [`SEL_W-1:0] axil_sel_t;

endpackage

`default_nettype wire

//--- verilog/axil_r_merge.sv
// Read response merger.
// Collects the DOWNSIZE_FACTOR narrow R beats into one wide R response,
// lowest beat in the lowest slice, with the OR of all beat response codes.
`timescale 1ns/10ps
`default_nettype none

`include "axil_dw_consts.svh"

module axil_r_merge (
  input  wire                         clk_i,
  input  wire                         rst_i,
  input  wire                         mst_valid_i,
  output logic                        mst_ready_o,
  input  axil_dw_pkg::axil_r_narrow_t mst_r_i,
  output logic                        slv_valid_o,
  input  wire                         slv_ready_i,
  output axil_dw_pkg::axil_r_wide_t   slv_r_o
);

  import axil_dw_pkg::*;

  // One holding register per beat except the last, which passes straight through.
  axil_r_narrow_t [`DOWNSIZE_FACTOR-2:0] hold_q;
  axil_sel_t                             sel_q;
  logic                                  last_beat;
  logic                                  beat_done;
  logic [1:0]                            resp_or;

  assign last_beat   = &sel_q;
  assign beat_done   = mst_valid_i & mst_ready_o;
  assign mst_ready_o = last_beat ? slv_ready_i : 1'b1;
  assign slv_valid_o = last_beat & mst_valid_i;

  for (genvar i = 0; i < `DOWNSIZE_FACTOR - 1; i++) begin : g_hold
    always_ff @(posedge clk_i) begin
      if (beat_done && (sel_q == axil_sel_t'(i))) begin
        hold_q[i] <= mst_r_i;
      end
    end
  end

  // The live beat fills the top slice, the held beats fill the lower ones.
  always_comb begin
    resp_or = mst_r_i.resp;
    slv_r_o.data[(`DOWNSIZE_FACTOR-1) * `AXIL_MST_DATA_W +: `AXIL_MST_DATA_W] = mst_r_i.data;
    for (int i = 0; i < `DOWNSIZE_FACTOR - 1; i++) begin
      resp_or = resp_or | hold_q[i].resp;
      slv_r_o.data[i * `AXIL_MST_DATA_W +: `AXIL_MST_DATA_W] = hold_q[i].data;
    end
    slv_r_o.resp = axil_resp_e'(resp_or);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q <= '0;
    end else if (beat_done) begin
      sel_q <= sel_q + axil_sel_t'(1);
    end
  end

  a_stable_r : assert property (@(posedge clk_i) disable iff (rst_i)
      (slv_valid_o && !slv_ready_i) |=> $stable(slv_r_o))
    else $error("R channel changed before its handshake.");

endmodule

`default_nettype wire

//--- verilog/axil_spill_reg.sv
// Two-entry spill register for one valid/ready channel.
// Both the valid and the ready path are cut by a register stage.
`timescale 1ns/10ps
`default_nettype none

module axil_spill_reg #(
  parameter type T = logic
) (
  input  wire  clk_i,
  input  wire  rst_i,
  input  wire  valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  wire  ready_i,
  output T     data_o
);

  // Entry A takes every incoming beat, entry B catches A when the output stalls.
  logic a_full_q;
  logic b_full_q;
  T     a_data_q;
  T     b_data_q;
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // A empties whenever B is free, either to the output or into B.
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  // A beat only moves into B when the consumer is not taking it.
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill | (a_full_q & ~a_drain);
      b_full_q <= b_fill | (b_full_q & ~b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B always holds the older beat, so it goes out first.
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  // Ready depends only on the fill state, never on ready_i.
  assign ready_o = ~a_full_q | ~b_full_q;

  // A stalled output beat stays on the bus until it is taken.
  a_stable_out : assert property (@(posedge clk_i) disable iff (rst_i)
      (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
    else $error("Spill register output changed under back-pressure.");

endmodule

`default_nettype wire

//--- verilog/axil_w_splitter.sv
// Write data splitter.
// One wide W beat becomes DOWNSIZE_FACTOR narrow W beats, each carrying the
// data and strobe lanes picked by the beat index, lowest lanes first.
`timescale 1ns/10ps
`default_nettype none

`include "axil_dw_consts.svh"

module axil_w_splitter (
  input  wire                         clk_i,
  input  wire                         rst_i,
  input  wire                         slv_valid_i,
  output logic                        slv_ready_o,
  input  axil_dw_pkg::axil_w_wide_t   slv_w_i,
  output logic                        mst_valid_o,
  input  wire                         mst_ready_i,
  output axil_dw_pkg::axil_w_narrow_t mst_w_o
);

  import axil_dw_pkg::*;

  axil_w_wide_t spill_w;
  logic         spill_valid;
  logic         spill_ready;
  axil_sel_t    sel_q;
  logic         last_beat;
  logic         beat_done;

  axil_spill_reg #(
    .T (axil_w_wide_t)
  ) i_spill (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (slv_valid_i),
    .ready_o (slv_ready_o),
    .data_i  (slv_w_i),
    .valid_o (spill_valid),
    .ready_i (spill_ready),
    .data_o  (spill_w)
  );

  assign last_beat   = &sel_q;
  assign beat_done   = mst_valid_o & mst_ready_i;
  // Every beat goes out, even one whose strobe slice is all zero.
  assign mst_valid_o = spill_valid;
  assign spill_ready = mst_ready_i & last_beat;

  // Lane slice selected by the current beat.
  assign mst_w_o.data = spill_w.data[sel_q * `AXIL_MST_DATA_W +: `AXIL_MST_DATA_W];
  assign mst_w_o.strb = spill_w.strb[sel_q * `AXIL_MST_STRB_W +: `AXIL_MST_STRB_W];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q <= '0;
    end else if (beat_done) begin
      sel_q <= sel_q + axil_sel_t'(1);
    end
  end

  a_stable_w : assert property (@(posedge clk_i) disable iff (rst_i)
      (mst_valid_o && !mst_ready_i) |=> $stable(mst_w_o))
    else $error("W channel changed before its handshake.");

endmodule

`default_nettype wire
